// ==== logic/vga_defines.svh ====
`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

// 640x480 at 60 Hz, counted in pixel clocks and lines
`define H_ACTIVE 10'd640
`define H_FRONT 10'd16
`define H_SYNC 10'd96
`define H_TOTAL 10'd800
`define V_ACTIVE 10'd480
`define V_FRONT 10'd10
`define V_SYNC 10'd2
`define V_TOTAL 10'd525

// palette, stored blue-green-red
`define COLOR_MENU_BG 24'h150088
`define COLOR_BOARD_BG 24'h123495
`define COLOR_LOGO 24'h20d0f0
`define COLOR_START_BTN 24'h30b040
`define COLOR_PLAYER_BTN 24'h40a0e0
`define COLOR_BANNER 24'hd0c020
`define COLOR_RANKINGS 24'he0e0e0
`define COLOR_ROW1 24'h604020
`define COLOR_ROW2 24'h705030
`define COLOR_ROW3 24'h806040
`define COLOR_TRAY 24'h204010
`define COLOR_FACE 24'hf0f0f0
`define COLOR_PIP 24'h101010
`define COLOR_ARROW 24'h1414ff

// sprite windows, x0 and y0 inclusive, x1 and y1 exclusive
`define LOGO_X0 10'd63
`define LOGO_X1 10'd559
`define LOGO_Y0 10'd81
`define LOGO_Y1 10'd186
`define START_X0 10'd228
`define START_X1 10'd400
`define START_Y0 10'd204
`define START_Y1 10'd373
`define PLAYER_X0 10'd230
`define PLAYER_X1 10'd405
`define PLAYER_Y0 10'd205
`define PLAYER_Y1 10'd464
`define BANNER_X0 10'd112
`define BANNER_X1 10'd524
`define BANNER_Y0 10'd58
`define BANNER_Y1 10'd149
`define RANK_X0 10'd122
`define RANK_X1 10'd185
`define RANK_Y0 10'd198
`define RANK_Y1 10'd401
`define ROW1_X0 10'd18
`define ROW1_X1 10'd617
`define ROW1_Y0 10'd18
`define ROW1_Y1 10'd97
`define ROW2_X0 10'd31
`define ROW2_X1 10'd615
`define ROW2_Y0 10'd124
`define ROW2_Y1 10'd227
`define ROW3_X0 10'd195
`define ROW3_X1 10'd437
`define ROW3_Y0 10'd257
`define ROW3_Y1 10'd320
`define TRAY_X0 10'd4
`define TRAY_X1 10'd635
`define TRAY_Y0 10'd344
`define TRAY_Y1 10'd463

// dice cells and cursor arrow
`define DIE_Y0 10'd345
`define DIE_SIZE 10'd120
`define DIE_X0 10'd4
`define DIE_X1 10'd131
`define DIE_X2 10'd256
`define DIE_X3 10'd383
`define DIE_X4 10'd510
`define ARROW_W 10'd25
`define ARROW_H 10'd19

`endif

// ==== logic/vga_pkg.sv ====
package vga_pkg;

	typedef logic [9:0] coord_t;
	typedef logic [23:0] color_t;
	typedef logic [7:0] channel_t;
	// 1 to 6 are faces, 0 and 7 leave the cell empty
	typedef logic [2:0] pip_t;
	typedef logic [3:0] slot_t;

	typedef enum logic [1:0] {
		SCR_START,
		SCR_PLAYERS,
		SCR_LEADERS,
		SCR_BOARD
	} screen_t;

	typedef enum logic [3:0] {
		LYR_BG,
		LYR_LOGO,
		LYR_START_BTN,
		LYR_PLAYER_BTN,
		LYR_LEADER_BANNER,
		LYR_RANKINGS,
		LYR_ROW1,
		LYR_ROW2,
		LYR_ROW3,
		LYR_TRAY,
		LYR_FACE,
		LYR_PIP,
		LYR_ARROW
	} layer_t;

	// half-open rectangle hit test
	function automatic logic in_win(input coord_t x, input coord_t y,
			input coord_t x0, input coord_t x1, input coord_t y0, input coord_t y1);
		return (x >= x0) && (x < x1) && (y >= y0) && (y < y1);
	endfunction

endpackage

// ==== logic/video_sync_gen.sv ====
`timescale 1ns/1ps
`include "vga_defines.svh"

module video_sync_gen import vga_pkg::*; (
	input  logic   VGA_CLK_n,
	input  logic   iRST_n,
	output coord_t pix_x,
	output coord_t pix_y,
	output logic   active,
	output logic   hs_raw,
	output logic   vs_raw
);

	localparam coord_t H_SYNC_START = `H_ACTIVE + `H_FRONT;
	localparam coord_t H_SYNC_END = `H_ACTIVE + `H_FRONT + `H_SYNC;
	localparam coord_t V_SYNC_START = `V_ACTIVE + `V_FRONT;
	localparam coord_t V_SYNC_END = `V_ACTIVE + `V_FRONT + `V_SYNC;

	coord_t h_cnt;
	coord_t v_cnt;
	logic   h_last;
	logic   v_last;

	assign h_last = (h_cnt == `H_TOTAL - 10'd1);
	assign v_last = (v_cnt == `V_TOTAL - 10'd1);

	//////////////////////////////
	// row-major scan, active region first
	//////////////////////////////
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_last) begin
			h_cnt <= '0;
			if (v_last) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 10'd1;
			end
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	assign pix_x = h_cnt;
	assign pix_y = v_cnt;

	assign active = (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);

	// both syncs active low
	assign hs_raw = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
	assign vs_raw = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));

endmodule

// ==== logic/dice_tray_renderer.sv ====
`timescale 1ns/1ps
`include "vga_defines.svh"

module dice_tray_renderer import vga_pkg::*; (
	input  coord_t pix_x,
	input  coord_t pix_y,
	input  pip_t   die1,
	input  pip_t   die2,
	input  pip_t   die3,
	input  pip_t   die4,
	input  pip_t   die5,
	output layer_t tray_layer
);

	// each die is a 3x3 grid of 40 pixel squares
	localparam coord_t GRID = 10'd40;
	localparam coord_t PIP_LO = 10'd12;
	localparam coord_t PIP_HI = 10'd28;
	localparam coord_t CELL_X0 [5] = '{`DIE_X0, `DIE_X1, `DIE_X2, `DIE_X3, `DIE_X4};

	pip_t       die_val [5];
	logic       in_cell;
	pip_t       cell_val;
	coord_t     off_x;
	coord_t     off_y;
	logic [1:0] col;
	logic [1:0] row;
	coord_t     sub_x;
	coord_t     sub_y;
	logic [3:0] square;
	logic [8:0] face_mask;
	logic       in_band;
	logic       pip_on;

	// bit r*3+c set where the face has a pip
	function automatic logic [8:0] pip_mask(input pip_t val);
		case (val)
			3'd1: return 9'b000_010_000;
			3'd2: return 9'b100_000_001;
			3'd3: return 9'b100_010_001;
			3'd4: return 9'b101_000_101;
			3'd5: return 9'b101_010_101;
			3'd6: return 9'b101_101_101;
			default: return 9'b000_000_000;
		endcase
	endfunction

	function automatic logic [1:0] grid_idx(input coord_t off);
		if (off >= GRID + GRID) return 2'd2;
		if (off >= GRID) return 2'd1;
		return 2'd0;
	endfunction

	assign die_val = '{die1, die2, die3, die4, die5};

	always_comb begin
		in_cell = 1'b0;
		cell_val = '0;
		off_x = '0;
		for (int i = 0; i < 5; i++) begin
			if ((pix_x >= CELL_X0[i]) && (pix_x < CELL_X0[i] + `DIE_SIZE)) begin
				in_cell = 1'b1;
				cell_val = die_val[i];
				off_x = pix_x - CELL_X0[i];
			end
		end
	end

	assign in_band = (pix_y >= `DIE_Y0) && (pix_y < `DIE_Y0 + `DIE_SIZE);
	assign off_y = pix_y - `DIE_Y0;
	assign col = grid_idx(off_x);
	assign row = grid_idx(off_y);
	assign sub_x = off_x - coord_t'(col) * GRID;
	assign sub_y = off_y - coord_t'(row) * GRID;
	assign square = {2'b00, row} * 4'd3 + {2'b00, col};
	assign face_mask = pip_mask(cell_val);
	assign pip_on = (sub_x >= PIP_LO) && (sub_x < PIP_HI) && (sub_y >= PIP_LO) &&
		(sub_y < PIP_HI) && face_mask[square];

	always_comb begin
		if (in_band && in_cell) begin
			if ((cell_val == 3'd0) || (cell_val == 3'd7)) begin
				tray_layer = LYR_TRAY;
			end else begin
				tray_layer = pip_on ? LYR_PIP : LYR_FACE;
			end
		end else if (in_win(pix_x, pix_y, `TRAY_X0, `TRAY_X1, `TRAY_Y0, `TRAY_Y1) ||
				(in_band && (pix_x >= `TRAY_X0) && (pix_x < `TRAY_X1))) begin
			// gaps between cells
			tray_layer = LYR_TRAY;
		end else begin
			tray_layer = LYR_BG;
		end
	end

endmodule

// ==== logic/hand_slot_marker.sv ====
`timescale 1ns/1ps
`include "vga_defines.svh"

module hand_slot_marker import vga_pkg::*; (
	input  logic    VGA_CLK_n,
	input  logic    iRST_n,
	input  coord_t  pix_x,
	input  coord_t  pix_y,
	input  screen_t screen_mode,
	input  slot_t   arrow_pos,
	input  slot_t   selected_hand,
	input  logic    select_strobe,
	output logic    arrow_hit
);

	localparam int NUM_SLOTS = 13;

	// arrow origins, upper row, middle row, then the lone bonus slot
	localparam coord_t SLOT_X [NUM_SLOTS] = '{
		10'd52, 10'd157, 10'd256, 10'd356, 10'd456, 10'd559,
		10'd65, 10'd163, 10'd257, 10'd349, 10'd448, 10'd545,
		10'd301
	};
	localparam coord_t SLOT_Y [NUM_SLOTS] = '{
		10'd102, 10'd102, 10'd102, 10'd102, 10'd102, 10'd102,
		10'd231, 10'd231, 10'd231, 10'd231, 10'd231, 10'd231,
		10'd322
	};

	logic [NUM_SLOTS-1:0] marks;

	//////////////////////////////
	// sticky chosen-hand marks
	//////////////////////////////
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			marks <= '0;
		end else if (screen_mode == SCR_START) begin
			// new game
			marks <= '0;
		end else if (select_strobe && (selected_hand <= 4'd12)) begin
			marks[selected_hand] <= 1'b1;
		end
	end

	// cursor slot or any marked slot shows an arrow
	always_comb begin
		arrow_hit = 1'b0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (((slot_t'(i) == arrow_pos) || marks[i]) &&
					in_win(pix_x, pix_y, SLOT_X[i], SLOT_X[i] + `ARROW_W,
					SLOT_Y[i], SLOT_Y[i] + `ARROW_H)) begin
				arrow_hit = 1'b1;
			end
		end
	end

endmodule

// ==== logic/screen_compositor.sv ====
`timescale 1ns/1ps
`include "vga_defines.svh"

module screen_compositor import vga_pkg::*; (
	input  logic     VGA_CLK_n,
	input  logic     iRST_n,
	input  coord_t   pix_x,
	input  coord_t   pix_y,
	input  logic     active,
	input  logic     hs_raw,
	input  logic     vs_raw,
	input  screen_t  screen_mode,
	input  layer_t   tray_layer,
	input  logic     arrow_hit,
	output logic     vga_hs,
	output logic     vga_vs,
	output logic     vga_blank_n,
	output channel_t r_data,
	output channel_t g_data,
	output channel_t b_data
);

	layer_t layer;
	color_t pix_color;
	color_t bgr_q;

	//////////////////////////////
	// layer priority per screen
	//////////////////////////////
	always_comb begin
		layer = LYR_BG;
		case (screen_mode)
			SCR_START: begin
				if (in_win(pix_x, pix_y, `LOGO_X0, `LOGO_X1, `LOGO_Y0, `LOGO_Y1))
					layer = LYR_LOGO;
				else if (in_win(pix_x, pix_y, `START_X0, `START_X1, `START_Y0, `START_Y1))
					layer = LYR_START_BTN;
			end
			SCR_PLAYERS: begin
				if (in_win(pix_x, pix_y, `LOGO_X0, `LOGO_X1, `LOGO_Y0, `LOGO_Y1))
					layer = LYR_LOGO;
				else if (in_win(pix_x, pix_y, `PLAYER_X0, `PLAYER_X1, `PLAYER_Y0, `PLAYER_Y1))
					layer = LYR_PLAYER_BTN;
			end
			SCR_LEADERS: begin
				if (in_win(pix_x, pix_y, `BANNER_X0, `BANNER_X1, `BANNER_Y0, `BANNER_Y1))
					layer = LYR_LEADER_BANNER;
				else if (in_win(pix_x, pix_y, `RANK_X0, `RANK_X1, `RANK_Y0, `RANK_Y1))
					layer = LYR_RANKINGS;
			end
			default: begin
				// arrows sit on top of the score card
				if (arrow_hit)
					layer = LYR_ARROW;
				else if (in_win(pix_x, pix_y, `ROW1_X0, `ROW1_X1, `ROW1_Y0, `ROW1_Y1))
					layer = LYR_ROW1;
				else if (in_win(pix_x, pix_y, `ROW2_X0, `ROW2_X1, `ROW2_Y0, `ROW2_Y1))
					layer = LYR_ROW2;
				else if (in_win(pix_x, pix_y, `ROW3_X0, `ROW3_X1, `ROW3_Y0, `ROW3_Y1))
					layer = LYR_ROW3;
				else
					layer = tray_layer;
			end
		endcase
	end

	// palette
	always_comb begin
		case (layer)
			LYR_LOGO:          pix_color = `COLOR_LOGO;
			LYR_START_BTN:     pix_color = `COLOR_START_BTN;
			LYR_PLAYER_BTN:    pix_color = `COLOR_PLAYER_BTN;
			LYR_LEADER_BANNER: pix_color = `COLOR_BANNER;
			LYR_RANKINGS:      pix_color = `COLOR_RANKINGS;
			LYR_ROW1:          pix_color = `COLOR_ROW1;
			LYR_ROW2:          pix_color = `COLOR_ROW2;
			LYR_ROW3:          pix_color = `COLOR_ROW3;
			LYR_TRAY:          pix_color = `COLOR_TRAY;
			LYR_FACE:          pix_color = `COLOR_FACE;
			LYR_PIP:           pix_color = `COLOR_PIP;
			LYR_ARROW:         pix_color = `COLOR_ARROW;
			default: pix_color = (screen_mode == SCR_BOARD) ? `COLOR_BOARD_BG : `COLOR_MENU_BG;
		endcase
	end

	// sync and colour leave on the same edge
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
			vga_blank_n <= 1'b0;
			bgr_q <= '0;
		end else begin
			vga_hs <= hs_raw;
			vga_vs <= vs_raw;
			vga_blank_n <= active;
			bgr_q <= active ? pix_color : '0;
		end
	end

	assign b_data = bgr_q[23:16];
	assign g_data = bgr_q[15:8];
	assign r_data = bgr_q[7:0];

endmodule

// ==== logic/yahtzee_vga.sv ====
`timescale 1ns/1ps

module yahtzee_vga import vga_pkg::*; (
	input  logic     VGA_CLK_n,
	input  logic     iRST_n,
	input  screen_t  screen_mode,
	input  pip_t     die1,
	input  pip_t     die2,
	input  pip_t     die3,
	input  pip_t     die4,
	input  pip_t     die5,
	input  slot_t    arrow_pos,
	input  slot_t    selected_hand,
	input  logic     select_strobe,
	output logic     vga_hs,
	output logic     vga_vs,
	output logic     vga_blank_n,
	output channel_t r_data,
	output channel_t g_data,
	output channel_t b_data
);

	coord_t pix_x;
	coord_t pix_y;
	logic   active;
	logic   hs_raw;
	logic   vs_raw;
	layer_t tray_layer;
	logic   arrow_hit;

	video_sync_gen u_sync (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n    (iRST_n),
		.pix_x     (pix_x),
		.pix_y     (pix_y),
		.active    (active),
		.hs_raw    (hs_raw),
		.vs_raw    (vs_raw)
	);

	dice_tray_renderer u_dice (
		.pix_x      (pix_x),
		.pix_y      (pix_y),
		.die1       (die1),
		.die2       (die2),
		.die3       (die3),
		.die4       (die4),
		.die5       (die5),
		.tray_layer (tray_layer)
	);

	hand_slot_marker u_marks (
		.VGA_CLK_n     (VGA_CLK_n),
		.iRST_n        (iRST_n),
		.pix_x         (pix_x),
		.pix_y         (pix_y),
		.screen_mode   (screen_mode),
		.arrow_pos     (arrow_pos),
		.selected_hand (selected_hand),
		.select_strobe (select_strobe),
		.arrow_hit     (arrow_hit)
	);

	screen_compositor u_comp (
		.VGA_CLK_n   (VGA_CLK_n),
		.iRST_n      (iRST_n),
		.pix_x       (pix_x),
		.pix_y       (pix_y),
		.active      (active),
		.hs_raw      (hs_raw),
		.vs_raw      (vs_raw),
		.screen_mode (screen_mode),
		.tray_layer  (tray_layer),
		.arrow_hit   (arrow_hit),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.vga_blank_n (vga_blank_n),
		.r_data      (r_data),
		.g_data      (g_data),
		.b_data      (b_data)
	);

endmodule

// ==== bench/yahtzee_vga_assert.sv ====
`timescale 1ns/1ps

module yahtzee_vga_assert import vga_pkg::*; (
	input logic     VGA_CLK_n,
	input logic     iRST_n,
	input logic     vga_hs,
	input logic     vga_vs,
	input logic     vga_blank_n,
	input channel_t r_data,
	input channel_t g_data,
	input channel_t b_data
);

	int hs_low_cnt;

	// low cycles of the current hs pulse, seen on the rising edge
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			hs_low_cnt <= 0;
		end else if (!vga_hs) begin
			hs_low_cnt <= hs_low_cnt + 1;
		end else begin
			hs_low_cnt <= 0;
		end
	end

	// outputs settle after the rising edge, so sample on the falling one
	hs_width: assert property (@(negedge VGA_CLK_n) disable iff (!iRST_n)
		$rose(vga_hs) |-> (hs_low_cnt == 96))
		else $error("vga_hs low pulse lasted %0d cycles", hs_low_cnt);

	rgb_blank: assert property (@(negedge VGA_CLK_n) disable iff (!iRST_n)
		!vga_blank_n |-> ({b_data, g_data, r_data} == 24'h0))
		else $error("colour is not black while vga_blank_n is low");

	vs_blank: assert property (@(negedge VGA_CLK_n) disable iff (!iRST_n)
		!vga_vs |-> !vga_blank_n)
		else $error("vga_blank_n is high during vertical sync");

endmodule

bind yahtzee_vga yahtzee_vga_assert yahtzee_vga_assert_inst (
	.VGA_CLK_n   (VGA_CLK_n),
	.iRST_n      (iRST_n),
	.vga_hs      (vga_hs),
	.vga_vs      (vga_vs),
	.vga_blank_n (vga_blank_n),
	.r_data      (r_data),
	.g_data      (g_data),
	.b_data      (b_data)
);

// ==== bench/tb_yahtzee_vga.sv ====
`timescale 1ns/1ps
`include "vga_defines.svh"

module tb_yahtzee_vga import vga_pkg::*; ();

	// eight frames of checks after reset, plus most of one spare frame
	localparam int TIMEOUT_CYCLES = 3_675_000;
	localparam int H_TOTAL = 800;
	localparam int V_TOTAL = 525;

	// arrow origins of the thirteen hand slots
	localparam int SLOT_X [13] = '{52, 157, 256, 356, 456, 559,
		65, 163, 257, 349, 448, 545, 301};
	localparam int SLOT_Y [13] = '{102, 102, 102, 102, 102, 102,
		231, 231, 231, 231, 231, 231, 322};
	localparam int DIE_X [5] = '{int'(`DIE_X0), int'(`DIE_X1), int'(`DIE_X2),
		int'(`DIE_X3), int'(`DIE_X4)};

	logic     VGA_CLK_n;
	logic     iRST_n;
	screen_t  screen_mode;
	pip_t     die_val [5];
	slot_t    arrow_pos;
	slot_t    selected_hand;
	logic     select_strobe;
	logic     vga_hs;
	logic     vga_vs;
	logic     vga_blank_n;
	channel_t r_data;
	channel_t g_data;
	channel_t b_data;

	// position currently shown on the registered outputs
	int          sh;
	int          sv;
	logic        shown_ok;
	int          dv [5];
	int          s0;
	int          cycles = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          tests_failed = 0;

	yahtzee_vga yahtzee_vga_inst (
		.VGA_CLK_n     (VGA_CLK_n),
		.iRST_n        (iRST_n),
		.screen_mode   (screen_mode),
		.die1          (die_val[0]),
		.die2          (die_val[1]),
		.die3          (die_val[2]),
		.die4          (die_val[3]),
		.die5          (die_val[4]),
		.arrow_pos     (arrow_pos),
		.selected_hand (selected_hand),
		.select_strobe (select_strobe),
		.vga_hs        (vga_hs),
		.vga_vs        (vga_vs),
		.vga_blank_n   (vga_blank_n),
		.r_data        (r_data),
		.g_data        (g_data),
		.b_data        (b_data)
	);

	initial begin
		VGA_CLK_n = 1'b0;
		forever #50 VGA_CLK_n = ~VGA_CLK_n;
	end

	//////////////////////////////
	// reference scan, one cycle behind the DUT counters
	//////////////////////////////
	always @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			shown_ok <= 1'b0;
			sh <= 0;
			sv <= 0;
		end else if (!shown_ok) begin
			shown_ok <= 1'b1;
		end else if (sh == H_TOTAL - 1) begin
			sh <= 0;
			sv <= (sv == V_TOTAL - 1) ? 0 : sv + 1;
		end else begin
			sh <= sh + 1;
		end
	end

	always @(posedge VGA_CLK_n) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d clock cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s at (%0d,%0d): got %h expected %h", name, sh, sv, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	// sync and blanking against the scan position, every cycle
	always @(negedge VGA_CLK_n) begin
		if (shown_ok) begin
			check_bit("vga_hs", vga_hs, !((sh >= 656) && (sh < 752)));
			check_bit("vga_vs", vga_vs, !((sv >= 490) && (sv < 492)));
			check_bit("vga_blank_n", vga_blank_n, (sh < 640) && (sv < 480));
			if (!vga_blank_n && ({b_data, g_data, r_data} != 24'h0)) begin
				errors++;
				$display("CHECK FAILED rgb at (%0d,%0d): got %h expected %h", sh, sv,
					{b_data, g_data, r_data}, 24'h0);
			end
		end
	end

	task automatic wait_pixel(input int x, input int y);
		@(negedge VGA_CLK_n);
		while (!(shown_ok && (sh == x) && (sv == y))) begin
			@(negedge VGA_CLK_n);
		end
	endtask

	task automatic check_pixel(input int x, input int y, input logic [23:0] exp);
		logic [23:0] got;
		wait_pixel(x, y);
		got = {b_data, g_data, r_data};
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED rgb at (%0d,%0d): got %h expected %h", x, y, got, exp);
		end
	endtask

	// inputs only change here
	task automatic enter_vblank();
		wait_pixel(0, 500);
	endtask

	task automatic strobe_hand(input int h);
		selected_hand = slot_t'(h);
		select_strobe = 1'b1;
		@(negedge VGA_CLK_n);
		select_strobe = 1'b0;
	endtask

	task automatic end_test(input string name, input int err0);
		tests++;
		if (errors == err0) begin
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: fail, %0d errors", name, errors - err0);
		end
	endtask

	// usual die faces on a 3x3 grid, column c and row r
	function automatic logic has_pip(input int val, input int c, input int r);
		logic centre;
		logic corner;
		logic diag;
		logic side;
		centre = (c == 1) && (r == 1);
		corner = (c != 1) && (r != 1);
		diag = ((c == 0) && (r == 0)) || ((c == 2) && (r == 2));
		side = (r == 1) && (c != 1);
		case (val)
			1: return centre;
			2: return diag;
			3: return diag || centre;
			4: return corner;
			5: return corner || centre;
			6: return corner || side;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [23:0] die_color(input int val, input int ox, input int oy);
		int sx;
		int sy;
		if ((val == 0) || (val == 7)) return `COLOR_TRAY;
		sx = ox % 40;
		sy = oy % 40;
		if ((sx >= 12) && (sx <= 27) && (sy >= 12) && (sy <= 27) && has_pip(val, ox / 40, oy / 40))
			return `COLOR_PIP;
		return `COLOR_FACE;
	endfunction

	// slot origin and the pixel just right of each arrow window
	task automatic check_slots(input logic [12:0] lit);
		for (int i = 0; i < 13; i++) begin
			check_pixel(SLOT_X[i], SLOT_Y[i], lit[i] ? `COLOR_ARROW : `COLOR_BOARD_BG);
			check_pixel(SLOT_X[i] + 25, SLOT_Y[i], `COLOR_BOARD_BG);
		end
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////
	task automatic test_sync();
		int err0;
		int lo;
		int per;
		err0 = errors;
		check_bit("vga_hs", vga_hs, 1'b1);
		check_bit("vga_vs", vga_vs, 1'b1);
		check_bit("vga_blank_n", vga_blank_n, 1'b0);
		check_count("rgb", int'({b_data, g_data, r_data}), 0);
		wait_pixel(639, 0);
		check_bit("vga_blank_n", vga_blank_n, 1'b1);
		wait_pixel(640, 0);
		check_bit("vga_blank_n", vga_blank_n, 1'b0);
		wait_pixel(655, 0);
		check_bit("vga_hs", vga_hs, 1'b1);
		@(negedge VGA_CLK_n);
		lo = 0;
		while (!vga_hs) begin
			lo++;
			@(negedge VGA_CLK_n);
		end
		per = lo;
		while (vga_hs) begin
			per++;
			@(negedge VGA_CLK_n);
		end
		check_count("vga_hs low cycles", lo, 96);
		check_count("vga_hs period", per, 800);
		wait_pixel(0, 479);
		check_bit("vga_blank_n", vga_blank_n, 1'b1);
		wait_pixel(0, 480);
		check_bit("vga_blank_n", vga_blank_n, 1'b0);
		wait_pixel(799, 489);
		check_bit("vga_vs", vga_vs, 1'b1);
		@(negedge VGA_CLK_n);
		lo = 0;
		while (!vga_vs) begin
			lo++;
			@(negedge VGA_CLK_n);
		end
		per = lo;
		while (vga_vs) begin
			per++;
			@(negedge VGA_CLK_n);
		end
		check_count("vga_vs low cycles", lo, 1600);
		check_count("vga_vs period", per, 420000);
		end_test("sync timing", err0);
	endtask

	task automatic test_menus();
		int err0;
		err0 = errors;
		// start screen has been up since reset
		check_pixel(10, 10, `COLOR_MENU_BG);
		check_pixel(62, 81, `COLOR_MENU_BG);
		check_pixel(63, 81, `COLOR_LOGO);
		check_pixel(558, 185, `COLOR_LOGO);
		check_pixel(559, 185, `COLOR_MENU_BG);
		check_pixel(300, 195, `COLOR_MENU_BG);
		check_pixel(227, 204, `COLOR_MENU_BG);
		check_pixel(228, 204, `COLOR_START_BTN);
		check_pixel(399, 372, `COLOR_START_BTN);
		check_pixel(400, 372, `COLOR_MENU_BG);
		check_pixel(300, 400, `COLOR_MENU_BG);
		enter_vblank();
		screen_mode = SCR_PLAYERS;
		check_pixel(63, 81, `COLOR_LOGO);
		check_pixel(229, 205, `COLOR_MENU_BG);
		check_pixel(230, 205, `COLOR_PLAYER_BTN);
		check_pixel(300, 400, `COLOR_PLAYER_BTN);
		check_pixel(404, 463, `COLOR_PLAYER_BTN);
		check_pixel(405, 463, `COLOR_MENU_BG);
		end_test("start and player select", err0);
	endtask

	task automatic test_leaders();
		int err0;
		err0 = errors;
		enter_vblank();
		screen_mode = SCR_LEADERS;
		check_pixel(10, 10, `COLOR_MENU_BG);
		check_pixel(111, 58, `COLOR_MENU_BG);
		check_pixel(112, 58, `COLOR_BANNER);
		check_pixel(523, 148, `COLOR_BANNER);
		check_pixel(524, 148, `COLOR_MENU_BG);
		check_pixel(122, 198, `COLOR_RANKINGS);
		check_pixel(300, 300, `COLOR_MENU_BG);
		check_pixel(184, 400, `COLOR_RANKINGS);
		check_pixel(185, 400, `COLOR_MENU_BG);
		end_test("leaderboard", err0);
	endtask

	task automatic test_dice();
		int err0;
		err0 = errors;
		enter_vblank();
		screen_mode = SCR_BOARD;
		for (int i = 0; i < 5; i++) begin
			dv[i] = int'($urandom % 8);
			die_val[i] = pip_t'(dv[i]);
		end
		s0 = int'($urandom % 13);
		arrow_pos = slot_t'(s0);
		check_pixel(17, 18, `COLOR_BOARD_BG);
		check_pixel(18, 18, `COLOR_ROW1);
		check_slots(13'd1 << s0);
		check_pixel(3, 344, `COLOR_BOARD_BG);
		check_pixel(4, 344, `COLOR_TRAY);
		// face corner, then top pips, then middle row and the gap after each die
		for (int i = 0; i < 5; i++) begin
			check_pixel(DIE_X[i] + 2, 347, die_color(dv[i], 2, 2));
		end
		for (int i = 0; i < 5; i++) begin
			check_pixel(DIE_X[i] + 20, 365, die_color(dv[i], 20, 20));
			check_pixel(DIE_X[i] + 100, 365, die_color(dv[i], 100, 20));
		end
		for (int i = 0; i < 5; i++) begin
			check_pixel(DIE_X[i] + 20, 405, die_color(dv[i], 20, 60));
			check_pixel(DIE_X[i] + 60, 405, die_color(dv[i], 60, 60));
			check_pixel(DIE_X[i] + 121, 405, `COLOR_TRAY);
		end
		end_test("dice tray", err0);
	endtask

	task automatic test_cursor();
		int err0;
		int s1;
		int h1;
		int h2;
		err0 = errors;
		s1 = int'($urandom % 13);
		while (s1 == s0) s1 = int'($urandom % 13);
		h1 = int'($urandom % 13);
		while ((h1 == s0) || (h1 == s1)) h1 = int'($urandom % 13);
		h2 = int'($urandom % 13);
		while ((h2 == s0) || (h2 == s1) || (h2 == h1)) h2 = int'($urandom % 13);
		enter_vblank();
		// pick two hands under the cursor, then a slot that does not exist
		arrow_pos = slot_t'(h1);
		strobe_hand(h1);
		arrow_pos = slot_t'(h2);
		strobe_hand(h2);
		strobe_hand(13);
		arrow_pos = slot_t'(s1);
		check_slots((13'd1 << s1) | (13'd1 << h1) | (13'd1 << h2));
		enter_vblank();
		screen_mode = SCR_START;
		@(negedge VGA_CLK_n);
		screen_mode = SCR_BOARD;
		check_slots(13'd1 << s1);
		end_test("cursor and marks", err0);
	endtask

	task automatic test_blanking();
		int err0;
		err0 = errors;
		check_pixel(645, 400, 24'h0);
		check_bit("vga_blank_n", vga_blank_n, 1'b0);
		check_pixel(700, 400, 24'h0);
		check_bit("vga_blank_n", vga_blank_n, 1'b0);
		check_pixel(780, 400, 24'h0);
		check_bit("vga_blank_n", vga_blank_n, 1'b0);
		check_pixel(100, 485, 24'h0);
		check_bit("vga_blank_n", vga_blank_n, 1'b0);
		end_test("blanking", err0);
	endtask

	initial begin
		void'($urandom(32'h9a8f));
		iRST_n = 1'b0;
		screen_mode = SCR_START;
		foreach (die_val[i]) die_val[i] = '0;
		arrow_pos = '0;
		selected_hand = '0;
		select_strobe = 1'b0;
		repeat (4) @(negedge VGA_CLK_n);
		iRST_n = 1'b1;
		test_sync();
		test_menus();
		test_leaders();
		test_dice();
		test_cursor();
		test_blanking();
		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, tests_failed,
			checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+logic
logic/vga_pkg.sv
logic/video_sync_gen.sv
logic/dice_tray_renderer.sv
logic/hand_slot_marker.sv
logic/screen_compositor.sv
logic/yahtzee_vga.sv
bench/yahtzee_vga_assert.sv
bench/tb_yahtzee_vga.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the VGA testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f \
	--top-module tb_yahtzee_vga --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -qF "*** PASSED ***" sim.log
